/* Makefile */
SIM = obj_dir/Vrx_align_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module rx_align_tb -f list.f

run: compile
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* align_ctrl.sv */
module align_ctrl
    import rx_ctrl_pkg::*;
#(
    parameter int TRAIN_TIMEOUT = 1000
) (
    input  logic         CLK_I,
    input  logic         RST_I,
    input  logic         start_stb,
    input  logic         align_done,
    output logic         clear_stb,
    output train_state_t train_state,
    output logic         locked
);

    localparam int TMR_W = $clog2(TRAIN_TIMEOUT + 1);

    train_state_t     state_q;
    train_state_t     state_d;
    logic [TMR_W-1:0] tmr_q;
    logic             tmr_expired;

    // Aligner is cleared in the same cycle as the start request
    assign clear_stb = start_stb;

    // Count reaches TRAIN_TIMEOUT on this edge
    assign tmr_expired = (tmr_q == TMR_W'(TRAIN_TIMEOUT - 1));

    //////////////////////////////
    // Training FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_TRAIN: begin
                if (align_done) begin
                    state_d = ST_LOCKED;
                end else if (tmr_expired) begin
                    state_d = ST_FAILED;
                end
            end
            default: ;                           // IDLE, LOCKED, FAILED hold
        endcase
        if (start_stb) begin
            state_d = ST_TRAIN;                  // Restart from any state
        end
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Attempt timer, runs only while training
    always_ff @(posedge CLK_I) begin
        if (RST_I || start_stb) begin
            tmr_q <= '0;
        end else if (state_q == ST_TRAIN) begin
            tmr_q <= tmr_q + TMR_W'(1);
        end
    end

    assign train_state = state_q;
    assign locked      = (state_q == ST_LOCKED);

endmodule

/* align_regs.sv */
module align_regs
    import rx_data_pkg::*, rx_ctrl_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic         CLK_I,
    input  logic         RST_I,
    input  logic         reg_wr,
    input  logic         reg_rd,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    output reg_data_t    reg_rdata,
    output logic         reg_rvalid,
    output logic         auto_mode,
    output data_word_t   pattern,
    output reg_data_t    threshold,
    output logic         start_stb,
    output logic         slip_stb,
    input  train_state_t train_state,
    input  shift_idx_t   sel_idx
);

    localparam reg_data_t THRESH_RST = 8'd16;

    logic      ctrl_wr;
    reg_data_t rd_mux;

    assign ctrl_wr = reg_wr && (reg_addr == ADDR_CTRL);

    //////////////////////////////
    // Configuration
    //////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            auto_mode <= 1'b1;
            pattern   <= '0;
            threshold <= THRESH_RST;
        end else if (reg_wr) begin
            case (reg_addr)
                ADDR_CTRL:    auto_mode <= reg_wdata[CTRL_AUTO];
                ADDR_PATTERN: pattern   <= data_word_t'(reg_wdata[DATA_W-1:0]);
                ADDR_THRESH:  threshold <= reg_wdata;
                default:      ;                  // STATUS is read only
            endcase
        end
    end

    // Command bits become single-cycle pulses
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            start_stb <= 1'b0;
            slip_stb  <= 1'b0;
        end else begin
            start_stb <= ctrl_wr & reg_wdata[CTRL_START];
            slip_stb  <= ctrl_wr & reg_wdata[CTRL_SLIP];
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            ADDR_CTRL:    rd_mux[CTRL_AUTO] = auto_mode;
            ADDR_PATTERN: rd_mux = pattern;
            ADDR_THRESH:  rd_mux = threshold;
            default:      rd_mux = {3'b000, sel_idx, train_state};
        endcase
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge CLK_I) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

/* byte_align.sv */
module byte_align
    import rx_data_pkg::*, rx_ctrl_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic       CLK_I,
    input  logic       RST_I,
    input  data_word_t data_in,
    input  logic       auto_mode,
    input  logic       slip_stb,
    input  logic       clear_stb,
    input  data_word_t pattern,
    input  reg_data_t  threshold,
    output data_word_t data_out,
    output shift_idx_t sel_idx,
    output logic       align_done
);

    logic [DATA_W-1:0]   word_new;       // Stage 1
    logic [DATA_W-1:0]   word_old;       // Stage 2
    logic [2*DATA_W-1:0] word_pair;
    logic [DATA_W-1:0]   cand [DATA_W];
    logic [DATA_W-1:0]   lock_flags;
    logic                done_q;
    shift_idx_t          slip_idx;
    shift_idx_t          lock_idx;

    //////////////////////////////
    // Input pipeline
    //////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            word_new <= '0;
            word_old <= '0;
        end else begin
            word_new <= data_in[DATA_W-1:0];
            word_old <= word_new;
        end
    end

    // Older word on top, so a window k bits down from the MSB is candidate k
    assign word_pair = {word_old, word_new};

    //////////////////////////////
    // Candidates and match logic
    //////////////////////////////

    for (genvar k = 0; k < DATA_W; k++) begin : g_shift
        logic [DATA_W-1:0] cand_q;
        reg_data_t         match_cnt;   // Consecutive matches, saturating
        logic              lock_q;

        always_ff @(posedge CLK_I) begin
            if (RST_I) begin
                cand_q <= '0;
            end else begin
                cand_q <= word_pair[2*DATA_W-1-k -: DATA_W];
            end
        end

        always_ff @(posedge CLK_I) begin
            if (RST_I || clear_stb) begin
                match_cnt <= '0;
                lock_q    <= 1'b0;
            end else begin
                if (cand_q != pattern[DATA_W-1:0]) begin
                    match_cnt <= '0;             // Run broken
                end else if (match_cnt != '1) begin
                    match_cnt <= match_cnt + reg_data_t'(1);
                end
                if (match_cnt == threshold) begin
                    lock_q <= 1'b1;              // Sticky until next clear
                end
            end
        end

        assign cand[k]       = cand_q;
        assign lock_flags[k] = lock_q;
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I || clear_stb) begin
            done_q <= 1'b0;
        end else begin
            done_q <= |lock_flags;
        end
    end

    // Hide a stale lock while the controller is clearing
    assign align_done = done_q & ~clear_stb;

    //////////////////////////////
    // Manual slip
    //////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            slip_idx <= '0;
        end else if (slip_stb && !auto_mode) begin
            if (slip_idx == shift_idx_t'(DATA_W - 1)) begin
                slip_idx <= '0;                  // Wrap
            end else begin
                slip_idx <= slip_idx + shift_idx_t'(1);
            end
        end
    end

    //////////////////////////////
    // Output select
    //////////////////////////////

    // Lowest locked shift wins
    always_comb begin
        lock_idx = '0;
        for (int k = DATA_W - 1; k >= 0; k--) begin
            if (lock_flags[k]) begin
                lock_idx = shift_idx_t'(k);
            end
        end
    end

    assign sel_idx  = auto_mode ? lock_idx : slip_idx;
    assign data_out = data_word_t'(cand[sel_idx]);

endmodule

/* list.f */
rx_data_pkg.sv
rx_ctrl_pkg.sv
byte_align.sv
align_regs.sv
align_ctrl.sv
rx_align_top.sv
rx_align_properties.sv
rx_align_tb.sv

/* rx_align_golden.txt */
auto_off0        1 b4 0 16 0  2 0 b4
auto_off3        1 b4 3 16 0  2 5 b4
relock_off6      1 b4 6 8  0  2 2 b4
auto_bc_off1     1 bc 1 12 0  2 7 bc
manual_slip3     0 b4 0 16 3  0 3 a5
manual_slip10    0 b4 2 16 10 0 2 4b
random_fail      1 00 0 16 0  3 0 00
relock_1f_off5   1 1f 5 20 0  2 3 1f

/* rx_align_properties.sv */
module rx_align_properties (
    input logic CLK_I,
    input logic RST_I,
    input logic clear_stb,
    input logic align_done,
    input logic reg_rd,
    input logic reg_rvalid,
    input logic start_stb
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////
    // Aligner
    //////////////////////////////

    // A clear must never leave a stale done behind it
    clear_hides_done: assert property (
        @(posedge CLK_I) disable iff (RST_I)
        clear_stb |=> !align_done
    ) else $error("align_done high in the cycle after clear_stb");

    //////////////////////////////
    // Register block
    //////////////////////////////

    rvalid_after_rd: assert property (
        @(posedge CLK_I) disable iff (RST_I)
        reg_rd |=> reg_rvalid
    ) else $error("reg_rvalid missing one cycle after reg_rd");

    rvalid_only_after_rd: assert property (
        @(posedge CLK_I) disable iff (RST_I)
        reg_rvalid |-> $past(reg_rd)
    ) else $error("reg_rvalid without a reg_rd in the cycle before");

    start_single_cycle: assert property (
        @(posedge CLK_I) disable iff (RST_I)
        start_stb |=> !start_stb
    ) else $error("start_stb held for two cycles");

endmodule

// Each instance watches only its own module, unused inputs tied low
bind byte_align rx_align_properties u_align_props (
    .CLK_I      (CLK_I),
    .RST_I      (RST_I),
    .clear_stb  (clear_stb),
    .align_done (align_done),
    .reg_rd     (1'b0),
    .reg_rvalid (1'b0),
    .start_stb  (1'b0)
);

bind align_regs rx_align_properties u_regs_props (
    .CLK_I      (CLK_I),
    .RST_I      (RST_I),
    .clear_stb  (1'b0),
    .align_done (1'b0),
    .reg_rd     (reg_rd),
    .reg_rvalid (reg_rvalid),
    .start_stb  (start_stb)
);

/* rx_align_tb.sv */
module rx_align_tb
    import rx_data_pkg::*, rx_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_W         = 8;
    localparam int TRAIN_TIMEOUT  = 200;
    localparam int TRAIN_WAIT_MAX = 2 * TRAIN_TIMEOUT;
    localparam int RVALID_WAIT    = 4;
    localparam int SETTLE_CYCLES  = 16;    // Output cycles checked per test

    localparam reg_data_t CMD_START  = reg_data_t'((1 << CTRL_AUTO) | (1 << CTRL_START));
    localparam reg_data_t CMD_MANUAL = '0;
    localparam reg_data_t CMD_SLIP   = reg_data_t'(1 << CTRL_SLIP);

    logic         CLK_I;
    logic         RST_I;
    data_word_t   data_in;
    data_word_t   data_out;
    logic         reg_wr;
    logic         reg_rd;
    reg_addr_t    reg_addr;
    reg_data_t    reg_wdata;
    reg_data_t    reg_rdata;
    logic         reg_rvalid;
    logic         locked;
    train_state_t train_state;

    data_word_t      stream_pattern;
    int              stream_offset;
    logic            stream_random;
    logic [31:0]     lcg_state;
    data_word_t      hist [3];             // Last three sampled words with the newest first
    logic [8*32-1:0] test_name;
    int              error_count;

    rx_align_top #(
        .DATA_W        (DATA_W),
        .TRAIN_TIMEOUT (TRAIN_TIMEOUT)
    ) UUT (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .data_in     (data_in),
        .data_out    (data_out),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .locked      (locked),
        .train_state (train_state)
    );

    initial begin
        CLK_I = 1'b0;
        forever #5 CLK_I = ~CLK_I;
    end

    //////////////////////////////
    // Stream model
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Stream word for a repeated pattern rotated left by the offset
    function automatic data_word_t pattern_word(input data_word_t pat, input int off);
        if (off == 0) begin
            return pat;
        end
        return (pat << off) | (pat >> (DATA_W - off));
    endfunction

    // Older word moved up by k with the top bits of the newer word below it
    function automatic data_word_t rule_candidate(input data_word_t older,
                                                  input data_word_t newer, input int k);
        if (k == 0) begin
            return older;
        end
        return (older << k) | (newer >> (DATA_W - k));
    endfunction

    initial begin : stream_gen
        data_in = '0;
        hist    = '{default: '0};
        forever begin
            @(posedge CLK_I);
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = data_in;             // Word taken by the DUT at this edge
            #1;
            if (stream_random) begin
                lcg_state = lcg_next(lcg_state);
                data_in   = lcg_state[23:16];
            end else begin
                data_in = pattern_word(stream_pattern, stream_offset);
            end
        end
    end

    //////////////////////////////
    // Checks and bus tasks
    //////////////////////////////

    task automatic abort_run(input string why);
        error_count++;
        $display("%0s", why);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        string msg;
        if (expected !== actual) begin
            msg = $sformatf("Mismatch in %0s (%0s): expected %0h, actual %0h",
                            test_name, what, expected, actual);
            abort_run(msg);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK_I);
            #1;
        end
    endtask

    task automatic apply_reset();
        RST_I = 1'b1;
        idle_cycles(3);
        RST_I = 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        idle_cycles(1);
        reg_wr = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        int waited;
        reg_rd   = 1'b1;
        reg_addr = addr;
        idle_cycles(1);
        reg_rd = 1'b0;
        waited = 0;
        while (!reg_rvalid) begin
            if (waited >= RVALID_WAIT) begin
                abort_run("Timeout: reg_rvalid never came after a register read");
            end
            idle_cycles(1);
            waited++;
        end
        data = reg_rdata;
    endtask

    task automatic read_expect(input reg_addr_t addr, input reg_data_t expected,
                               input string what);
        reg_data_t value;
        bus_read(addr, value);
        check_value(what, 32'(expected), 32'(value));
    endtask

    task automatic wait_train_end();
        int waited;
        waited = 0;
        while (train_state == ST_TRAIN) begin
            if (waited >= TRAIN_WAIT_MAX) begin
                abort_run("Timeout: training attempt never finished");
            end
            idle_cycles(1);
            waited++;
        end
    endtask

    task automatic check_output(input int sel, input data_word_t expected,
                                input logic with_data, input int exp_state);
        repeat (SETTLE_CYCLES) begin
            check_value("train_state", 32'(exp_state), 32'(train_state));
            check_value("locked", 32'(exp_state == ST_LOCKED), 32'(locked));
            check_value("data_out vs stream",
                        32'(rule_candidate(hist[2], hist[1], sel)), 32'(data_out));
            if (with_data) begin
                check_value("data_out", 32'(expected), 32'(data_out));
            end
            idle_cycles(1);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    task automatic run_test(input int mode, input data_word_t pat, input int offset,
                            input int thresh, input int slips, input int exp_state,
                            input int exp_sel, input data_word_t exp_data);
        reg_data_t status_exp;
        status_exp = reg_data_t'((exp_sel << 2) | exp_state);
        if (mode == 0) begin
            apply_reset();                 // Slip index starts from zero
        end
        stream_random  = (pat == '0);
        stream_pattern = pat;
        stream_offset  = offset % DATA_W;
        bus_write(ADDR_THRESH, reg_data_t'(thresh));
        bus_write(ADDR_PATTERN, pat);
        read_expect(ADDR_THRESH, reg_data_t'(thresh), "THRESH readback");
        read_expect(ADDR_PATTERN, pat, "PATTERN readback");
        if (mode != 0) begin
            bus_write(ADDR_CTRL, CMD_START);
            idle_cycles(1);
            read_expect(ADDR_STATUS, reg_data_t'(ST_TRAIN), "STATUS while training");
            wait_train_end();
        end else begin
            bus_write(ADDR_CTRL, CMD_MANUAL);
            repeat (slips) bus_write(ADDR_CTRL, CMD_SLIP);
            idle_cycles(2);                // Let the last slip land
        end
        read_expect(ADDR_STATUS, status_exp, "STATUS");
        check_output(exp_sel, exp_data, !stream_random, exp_state);
    endtask

    initial begin : main
        int         fd;
        int         mode;
        int         offset;
        int         thresh;
        int         slips;
        int         exp_state;
        int         exp_sel;
        int         n_tests;
        data_word_t pat;
        data_word_t exp_data;
        RST_I          = 1'b1;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = ADDR_CTRL;
        reg_wdata      = '0;
        stream_pattern = '0;
        stream_offset  = 0;
        stream_random  = 1'b0;
        lcg_state      = 32'ha8f2;
        error_count    = 0;
        n_tests        = 0;
        test_name      = '0;
        test_name[8*11-1:0] = "after_reset";
        apply_reset();
        read_expect(ADDR_STATUS, reg_data_t'(ST_IDLE), "STATUS after reset");
        check_value("locked after reset", 32'd0, 32'(locked));
        check_value("train_state after reset", 32'(ST_IDLE), 32'(train_state));

        fd = $fopen("rx_align_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open rx_align_golden.txt");
        end
        while ($fscanf(fd, "%s %d %h %d %d %d %d %d %h", test_name, mode, pat, offset,
                       thresh, slips, exp_state, exp_sel, exp_data) == 9) begin
            run_test(mode, pat, offset, thresh, slips, exp_state, exp_sel, exp_data);
            n_tests++;
        end
        $fclose(fd);
        if (n_tests == 0) begin
            abort_run("No test cases found in rx_align_golden.txt");
        end

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* rx_align_top.sv */
module rx_align_top
    import rx_data_pkg::*, rx_ctrl_pkg::*;
#(
    parameter int DATA_W        = 8,
    parameter int TRAIN_TIMEOUT = 1000
) (
    input  logic         CLK_I,
    input  logic         RST_I,
    input  data_word_t   data_in,
    output data_word_t   data_out,
    input  logic         reg_wr,
    input  logic         reg_rd,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    output reg_data_t    reg_rdata,
    output logic         reg_rvalid,
    output logic         locked,
    output train_state_t train_state
);

    logic       auto_mode;
    data_word_t pattern;
    reg_data_t  threshold;
    logic       start_stb;
    logic       slip_stb;
    logic       clear_stb;
    logic       align_done;
    shift_idx_t sel_idx;

    align_regs #(
        .DATA_W      (DATA_W)
    ) u_regs (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .auto_mode   (auto_mode),
        .pattern     (pattern),
        .threshold   (threshold),
        .start_stb   (start_stb),
        .slip_stb    (slip_stb),
        .train_state (train_state),
        .sel_idx     (sel_idx)
    );

    align_ctrl #(
        .TRAIN_TIMEOUT (TRAIN_TIMEOUT)
    ) u_ctrl (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .start_stb   (start_stb),
        .align_done  (align_done),
        .clear_stb   (clear_stb),
        .train_state (train_state),
        .locked      (locked)
    );

    byte_align #(
        .DATA_W      (DATA_W)
    ) u_align (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .data_in     (data_in),
        .auto_mode   (auto_mode),
        .slip_stb    (slip_stb),
        .clear_stb   (clear_stb),
        .pattern     (pattern),
        .threshold   (threshold),
        .data_out    (data_out),
        .sel_idx     (sel_idx),
        .align_done  (align_done)
    );

endmodule

/* rx_ctrl_pkg.sv */
package rx_ctrl_pkg;

    //////////////////////////////
    // Register bus
    //////////////////////////////

    typedef logic [1:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    localparam reg_addr_t ADDR_CTRL    = 2'd0;
    localparam reg_addr_t ADDR_PATTERN = 2'd1;
    localparam reg_addr_t ADDR_THRESH  = 2'd2;
    localparam reg_addr_t ADDR_STATUS  = 2'd3;   // Read only

    // CTRL bits, START and SLIP are self-clearing
    localparam int CTRL_AUTO  = 0;
    localparam int CTRL_START = 1;
    localparam int CTRL_SLIP  = 2;

    //////////////////////////////
    // Training FSM
    //////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_TRAIN  = 2'd1,
        ST_LOCKED = 2'd2,
        ST_FAILED = 2'd3
    } train_state_t;

endpackage

/* rx_data_pkg.sv */
package rx_data_pkg;

    //////////////////////////////
    // Link word types
    //////////////////////////////

    // Widest word the aligner is built for
    localparam int WORD_W  = 8;

    // Enough index bits for WORD_W candidates
    localparam int SHIFT_W = $clog2(WORD_W);

    // One deserialized link word, narrower links use the low bits
    typedef logic [WORD_W-1:0] data_word_t;

    // Bit shift between the raw stream and the aligned word
    typedef logic [SHIFT_W-1:0] shift_idx_t;

endpackage
